// ==== verilog.f ====
hdl/udp_pkg.sv
hdl/stream_fifo.sv
hdl/udp_csum_engine.sv
hdl/udp_csum_top.sv
verif/clk_rst_gen.sv
verif/tb_udp_csum.sv

// ==== Bender.yml ====
package:
  name: udp_csum

sources:
  - files:
      - hdl/udp_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/udp_csum_engine.sv
      - hdl/udp_csum_top.sv
  - target: simulation
    files:
      - verif/clk_rst_gen.sv
      - verif/tb_udp_csum.sv

// ==== verif/tb_udp_csum.sv ====
// testbench for the UDP checksum core
// frame stimulus, reference checksum, output monitors and final report

`timescale 1ns/1ps

module tb_udp_csum;

    localparam int ACCEPT_TIMEOUT = 2000;
    localparam int DRAIN_TIMEOUT  = 20000;
    localparam int IDLE_TIMEOUT   = 50;

    logic                  clk;
    logic                  rst;
    udp_pkg::udp_in_hdr_t  s_hdr;
    logic                  s_hdr_valid;
    logic                  s_hdr_ready;
    udp_pkg::udp_beat_t    s_payload;
    logic                  s_payload_valid;
    logic                  s_payload_ready;
    udp_pkg::udp_out_hdr_t m_hdr;
    logic [15:0]           m_ip_length;
    logic                  m_hdr_valid;
    logic                  m_hdr_ready;
    udp_pkg::udp_beat_t    m_payload;
    logic                  m_payload_valid;
    logic                  m_payload_ready;
    logic                  busy;

    int  seed;
    int  error_count;
    int  hdr_count;
    int  byte_count;
    bit  aborted;
    bit  stall_outputs;

    // expected results filled by the stimulus and drained by the monitors
    udp_pkg::udp_out_hdr_t exp_hdr_q [$];
    udp_pkg::udp_beat_t    exp_beat_q [$];
    udp_pkg::udp_out_hdr_t exp_hdr;
    udp_pkg::udp_beat_t    exp_beat;
    logic [7:0]            frame_bytes [0:63];

    clk_rst_gen #(.PERIOD(10), .RESET_CYCLES(5)) clk_rst_gen_i (
        .clk (clk),
        .rst (rst)
    );

    udp_csum_top udp_csum_top_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr           (s_hdr),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr           (m_hdr),
        .m_ip_length     (m_ip_length),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .busy            (busy)
    );

    // sum of pseudo header, UDP header and big endian payload words, then fold and invert
    function automatic logic [15:0] ref_checksum(input udp_pkg::udp_in_hdr_t h, input int n);
        logic [31:0] acc;
        logic [15:0] udp_len;
        logic [15:0] word;
        logic [16:0] folded;
        logic [15:0] result;
        int          i;
        udp_len = n + 8;
        acc = 32'h11 + {15'h0, udp_len, 1'b0};
        acc = acc + {16'h0, h.ip_source_ip[31:16]} + {16'h0, h.ip_source_ip[15:0]};
        acc = acc + {16'h0, h.ip_dest_ip[31:16]} + {16'h0, h.ip_dest_ip[15:0]};
        acc = acc + {16'h0, h.udp_source_port} + {16'h0, h.udp_dest_port};
        for (i = 0; i < n; i = i + 2) begin
            // odd tail byte padded with zero in the low half
            word = {frame_bytes[i], (i + 1 < n) ? frame_bytes[i + 1] : 8'h00};
            acc = acc + {16'h0, word};
        end
        folded = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};
        result = folded[15:0] + {15'h0, folded[16]};
        return ~result;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_hdr_accept();
        int n;
        bit accepted;
        accepted = 1'b0;
        for (n = 0; n < ACCEPT_TIMEOUT && !accepted; n++) begin
            @(negedge clk);
            accepted = s_hdr_ready;
            @(posedge clk);
            #1;
        end
        if (!accepted) begin
            $display("error at %0t: header was not accepted before the timeout", $time);
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_beat_accept();
        int n;
        bit accepted;
        accepted = 1'b0;
        for (n = 0; n < ACCEPT_TIMEOUT && !accepted; n++) begin
            @(negedge clk);
            accepted = s_payload_ready;
            @(posedge clk);
            #1;
        end
        if (!accepted) begin
            $display("error at %0t: payload byte was not accepted before the timeout", $time);
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic send_frame(input int n);
        udp_pkg::udp_in_hdr_t  hdr;
        udp_pkg::udp_out_hdr_t expect_hdr;
        udp_pkg::udp_beat_t    beat;
        int                    i;
        hdr.ip_source_ip    = $random(seed);
        hdr.ip_dest_ip      = $random(seed);
        hdr.udp_source_port = $random(seed);
        hdr.udp_dest_port   = $random(seed);
        for (i = 0; i < n; i++) begin
            frame_bytes[i] = $random(seed);
        end
        expect_hdr.ip_source_ip    = hdr.ip_source_ip;
        expect_hdr.ip_dest_ip      = hdr.ip_dest_ip;
        expect_hdr.udp_source_port = hdr.udp_source_port;
        expect_hdr.udp_dest_port   = hdr.udp_dest_port;
        expect_hdr.udp_length      = n + 8;
        expect_hdr.udp_checksum    = ref_checksum(hdr, n);
        exp_hdr_q.push_back(expect_hdr);
        for (i = 0; i < n; i++) begin
            beat.data = frame_bytes[i];
            beat.last = (i == n - 1);
            exp_beat_q.push_back(beat);
        end
        s_hdr       = hdr;
        s_hdr_valid = 1'b1;
        wait_hdr_accept();
        s_hdr_valid = 1'b0;
        if (!aborted) begin
            // engine is summing the header words now
            compare_value("busy", 32'h1, {31'h0, busy});
        end
        for (i = 0; i < n && !aborted; i++) begin
            beat.data       = frame_bytes[i];
            beat.last       = (i == n - 1);
            s_payload       = beat;
            s_payload_valid = 1'b1;
            wait_beat_accept();
        end
        s_payload_valid = 1'b0;
    endtask

    // every expected header and byte must come out
    task automatic drain_outputs();
        int n;
        bit drained;
        drained = 1'b0;
        for (n = 0; n < DRAIN_TIMEOUT && !drained; n++) begin
            @(posedge clk);
            #1;
            drained = (exp_hdr_q.size() == 0) && (exp_beat_q.size() == 0);
        end
        if (!drained) begin
            $display("error at %0t: outputs still missing %0d headers and %0d bytes",
                     $time, exp_hdr_q.size(), exp_beat_q.size());
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_idle();
        int n;
        bit idle_seen;
        idle_seen = 1'b0;
        for (n = 0; n < IDLE_TIMEOUT && !idle_seen; n++) begin
            @(negedge clk);
            idle_seen = !busy;
            @(posedge clk);
            #1;
        end
        if (!idle_seen) begin
            $display("error at %0t: busy did not return low after the last frame", $time);
            error_count++;
        end
    endtask

    task automatic wait_reset_release();
        int n;
        bit released;
        released = 1'b0;
        for (n = 0; n < 100 && !released; n++) begin
            @(posedge clk);
            #1;
            released = !rst;
        end
        if (!released) begin
            $display("error at %0t: reset never released", $time);
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic report();
        $display("errors: %0d, headers: %0d, bytes: %0d", error_count, hdr_count, byte_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // output ready randomly held low during the stress phase
    always @(posedge clk) begin
        #1;
        if (stall_outputs) begin
            m_hdr_ready     = ($random(seed) & 3) == 0;
            m_payload_ready = ($random(seed) & 1) != 0;
        end else begin
            m_hdr_ready     = 1'b1;
            m_payload_ready = 1'b1;
        end
    end

    // header monitor sampling mid cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (!rst && m_hdr_valid && m_hdr_ready) begin
            hdr_count++;
            if (exp_hdr_q.size() == 0) begin
                $display("error at %0t: header arrived with none expected", $time);
                error_count++;
            end else begin
                exp_hdr = exp_hdr_q.pop_front();
                compare_value("m_hdr.ip_source_ip", exp_hdr.ip_source_ip, m_hdr.ip_source_ip);
                compare_value("m_hdr.ip_dest_ip", exp_hdr.ip_dest_ip, m_hdr.ip_dest_ip);
                compare_value("m_hdr.udp_source_port", {16'h0, exp_hdr.udp_source_port},
                              {16'h0, m_hdr.udp_source_port});
                compare_value("m_hdr.udp_dest_port", {16'h0, exp_hdr.udp_dest_port},
                              {16'h0, m_hdr.udp_dest_port});
                compare_value("m_hdr.udp_length", {16'h0, exp_hdr.udp_length},
                              {16'h0, m_hdr.udp_length});
                compare_value("m_hdr.udp_checksum", {16'h0, exp_hdr.udp_checksum},
                              {16'h0, m_hdr.udp_checksum});
                compare_value("m_ip_length", {16'h0, exp_hdr.udp_length + 16'd20},
                              {16'h0, m_ip_length});
            end
        end
    end

    // payload monitor
    always @(negedge clk) begin
        if (!rst && m_payload_valid && m_payload_ready) begin
            byte_count++;
            if (exp_beat_q.size() == 0) begin
                $display("error at %0t: payload byte arrived with none expected", $time);
                error_count++;
            end else begin
                exp_beat = exp_beat_q.pop_front();
                compare_value("m_payload.data", {24'h0, exp_beat.data}, {24'h0, m_payload.data});
                compare_value("m_payload.last", {31'h0, exp_beat.last}, {31'h0, m_payload.last});
            end
        end
    end

    initial begin
        int i;
        seed            = 32'h4d3f5ee3;
        error_count     = 0;
        hdr_count       = 0;
        byte_count      = 0;
        aborted         = 1'b0;
        stall_outputs   = 1'b0;
        s_hdr           = '0;
        s_hdr_valid     = 1'b0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        m_hdr_ready     = 1'b0;
        m_payload_ready = 1'b0;

        wait_reset_release();
        if (!aborted) begin
            // outputs quiet right after reset
            @(negedge clk);
            compare_value("m_hdr_valid", 32'h0, {31'h0, m_hdr_valid});
            compare_value("m_payload_valid", 32'h0, {31'h0, m_payload_valid});
            compare_value("busy", 32'h0, {31'h0, busy});
            compare_value("s_hdr_ready", 32'h0, {31'h0, s_hdr_ready});
            compare_value("s_payload_ready", 32'h0, {31'h0, s_payload_ready});
            @(posedge clk);
            #1;
        end

        // single frames of random, one byte, even and odd length
        if (!aborted) send_frame(1 + ($unsigned($random(seed)) % 64));
        if (!aborted) drain_outputs();
        if (!aborted) send_frame(1);
        if (!aborted) drain_outputs();
        if (!aborted) send_frame(2);
        if (!aborted) drain_outputs();
        if (!aborted) send_frame(7);
        if (!aborted) drain_outputs();
        if (!aborted) send_frame(64);
        if (!aborted) drain_outputs();

        // back to back frames against random output back-pressure
        stall_outputs = 1'b1;
        for (i = 0; i < 20 && !aborted; i++) begin
            send_frame(1 + ($unsigned($random(seed)) % 64));
        end
        if (!aborted) drain_outputs();
        stall_outputs = 1'b0;
        if (!aborted) wait_idle();

        report();
    end

endmodule

// ==== verif/clk_rst_gen.sv ====
// testbench clock and reset source
// free running clock, synchronous reset held for a fixed number of cycles

`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release on a rising edge so the DUT sees a clean synchronous reset
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== hdl/udp_csum_top.sv ====
// UDP length and checksum core
// checksum engine feeding a payload byte FIFO and a header FIFO
// IP total length derived on the header output

`timescale 1ns/1ps

module udp_csum_top (
    input  logic                  clk,
    input  logic                  rst,

    input  udp_pkg::udp_in_hdr_t  s_hdr,
    input  logic                  s_hdr_valid,
    output logic                  s_hdr_ready,

    input  udp_pkg::udp_beat_t    s_payload,
    input  logic                  s_payload_valid,
    output logic                  s_payload_ready,

    output udp_pkg::udp_out_hdr_t m_hdr,
    output logic [15:0]           m_ip_length,
    output logic                  m_hdr_valid,
    input  logic                  m_hdr_ready,

    output udp_pkg::udp_beat_t    m_payload,
    output logic                  m_payload_valid,
    input  logic                  m_payload_ready,

    output logic                  busy
);

    // engine to payload FIFO
    udp_pkg::udp_beat_t    beat;
    logic                  beat_valid;
    logic                  beat_ready;

    // engine to header FIFO
    udp_pkg::udp_out_hdr_t done_hdr;
    logic                  done_valid;
    logic                  hdr_space;

    udp_csum_engine engine_i (
        .clk             (clk),
        .rst             (rst),
        .s_hdr           (s_hdr),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .fifo_beat       (beat),
        .fifo_beat_valid (beat_valid),
        .fifo_beat_ready (beat_ready),
        .done_hdr        (done_hdr),
        .done_valid      (done_valid),
        .hdr_space       (hdr_space),
        .busy            (busy)
    );

    stream_fifo #(
        .data_t (udp_pkg::udp_beat_t),
        .DEPTH  (udp_pkg::PAYLOAD_FIFO_DEPTH)
    ) payload_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (beat),
        .wr_valid (beat_valid),
        .wr_ready (beat_ready),
        .rd_data  (m_payload),
        .rd_valid (m_payload_valid),
        .rd_ready (m_payload_ready)
    );

    stream_fifo #(
        .data_t (udp_pkg::udp_out_hdr_t),
        .DEPTH  (udp_pkg::HEADER_FIFO_DEPTH)
    ) header_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (done_hdr),
        .wr_valid (done_valid),
        .wr_ready (hdr_space),
        .rd_data  (m_hdr),
        .rd_valid (m_hdr_valid),
        .rd_ready (m_hdr_ready)
    );

    // IP total length without options
    assign m_ip_length = m_hdr.udp_length + udp_pkg::IP_HDR_LEN;

endmodule

// ==== hdl/udp_csum_engine.sv ====
// UDP checksum FSM with header capture register
// ones complement accumulator over pseudo header, header and payload
// payload gating towards the payload FIFO

`timescale 1ns/1ps

module udp_csum_engine (
    input  logic                 clk,
    input  logic                 rst,

    input  udp_pkg::udp_in_hdr_t s_hdr,
    input  logic                 s_hdr_valid,
    output logic                 s_hdr_ready,

    input  udp_pkg::udp_beat_t   s_payload,
    input  logic                 s_payload_valid,
    output logic                 s_payload_ready,

    output udp_pkg::udp_beat_t   fifo_beat,
    output logic                 fifo_beat_valid,
    input  logic                 fifo_beat_ready,

    output udp_pkg::udp_out_hdr_t done_hdr,
    output logic                 done_valid,
    input  logic                 hdr_space,

    output logic                 busy
);

    udp_pkg::csum_state_t state;
    udp_pkg::csum_state_t state_next;

    // captured header and running sums
    udp_pkg::udp_in_hdr_t hdr_reg;
    logic [31:0] sum;
    logic [31:0] sum_next;
    logic [15:0] len;
    logic [15:0] len_next;

    logic        capture;
    logic        hdr_ready_next;
    logic        done_valid_next;
    logic        in_payload;
    logic [16:0] fold;

    // payload only flows while the FSM is summing it
    assign in_payload      = state == udp_pkg::sum_payload;
    assign fifo_beat       = s_payload;
    assign fifo_beat_valid = s_payload_valid && in_payload;
    assign s_payload_ready = fifo_beat_ready && in_payload;

    // first fold of the 32 bit sum, carry added back in finish
    assign fold = {1'b0, sum[15:0]} + {1'b0, sum[31:16]};

    always_comb begin
        state_next      = state;
        sum_next        = sum;
        len_next        = len;
        hdr_ready_next  = 1'b0;
        done_valid_next = 1'b0;
        capture         = 1'b0;

        case (state)
            udp_pkg::idle: begin
                // hold off while the previous header is being written
                hdr_ready_next = hdr_space && !done_valid;
                if (s_hdr_valid && s_hdr_ready) begin
                    capture        = 1'b1;
                    hdr_ready_next = 1'b0;
                    // protocol plus both length fields of the bare header
                    sum_next   = {24'h0, udp_pkg::UDP_PROTO}
                               + {15'h0, udp_pkg::UDP_HDR_LEN, 1'b0};
                    state_next = udp_pkg::sum_hdr_1;
                end
            end
            udp_pkg::sum_hdr_1: begin
                sum_next   = sum + {16'h0, hdr_reg.ip_source_ip[31:16]}
                                 + {16'h0, hdr_reg.ip_source_ip[15:0]};
                state_next = udp_pkg::sum_hdr_2;
            end
            udp_pkg::sum_hdr_2: begin
                sum_next   = sum + {16'h0, hdr_reg.ip_dest_ip[31:16]}
                                 + {16'h0, hdr_reg.ip_dest_ip[15:0]};
                state_next = udp_pkg::sum_hdr_3;
            end
            udp_pkg::sum_hdr_3: begin
                sum_next   = sum + {16'h0, hdr_reg.udp_source_port}
                                 + {16'h0, hdr_reg.udp_dest_port};
                len_next   = udp_pkg::UDP_HDR_LEN;
                state_next = udp_pkg::sum_payload;
            end
            udp_pkg::sum_payload: begin
                if (s_payload_valid && s_payload_ready) begin
                    // even offset is the high byte of a word
                    // each byte also adds 1 to both length fields
                    if (len[0]) begin
                        sum_next = sum + {24'h0, s_payload.data} + 32'd2;
                    end else begin
                        sum_next = sum + {16'h0, s_payload.data, 8'h00} + 32'd2;
                    end
                    len_next = len + 16'd1;
                    if (s_payload.last) begin
                        state_next = udp_pkg::finish;
                    end
                end
            end
            udp_pkg::finish: begin
                // end around carry then invert
                sum_next        = {16'h0, ~(fold[15:0] + {15'h0, fold[16]})};
                done_valid_next = 1'b1;
                state_next      = udp_pkg::idle;
            end
            default: begin
                state_next = udp_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= udp_pkg::idle;
            s_hdr_ready <= 1'b0;
            done_valid  <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            s_hdr_ready <= hdr_ready_next;
            done_valid  <= done_valid_next;
            busy        <= state_next != udp_pkg::idle;
        end

        sum <= sum_next;
        len <= len_next;

        if (capture) begin
            hdr_reg <= s_hdr;
        end
    end

    // finished header, valid for the one cycle after finish
    always_comb begin
        done_hdr.ip_source_ip    = hdr_reg.ip_source_ip;
        done_hdr.ip_dest_ip      = hdr_reg.ip_dest_ip;
        done_hdr.udp_source_port = hdr_reg.udp_source_port;
        done_hdr.udp_dest_port   = hdr_reg.udp_dest_port;
        done_hdr.udp_length      = len;
        done_hdr.udp_checksum    = sum[15:0];
    end

endmodule

// ==== hdl/stream_fifo.sv ====
// synchronous valid/ready FIFO with a registered read stage
// payload type and depth are parameters, depth must be a power of two

`timescale 1ns/1ps

module stream_fifo #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,

    input  data_t wr_data,
    input  logic  wr_valid,
    output logic  wr_ready,

    output data_t rd_data,
    output logic  rd_valid,
    input  logic  rd_ready
);

    // storage, no reset needed
    data_t mem [DEPTH];

    // pointers carry one extra wrap bit
    logic [$clog2(DEPTH):0] wr_ptr;
    logic [$clog2(DEPTH):0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    // full when only the wrap bits differ
    assign full  = (wr_ptr ^ rd_ptr) == {1'b1, {$clog2(DEPTH){1'b0}}};
    assign empty = wr_ptr == rd_ptr;

    assign wr_ready = !full;
    assign wr_en    = wr_valid && !full;

    // refill the output stage when it is empty or being taken
    assign rd_en = !empty && (!rd_valid || rd_ready);

    // write side
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end

        if (wr_en) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= wr_data;
        end
    end

    // read side with output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                // entry taken and nothing behind it
                rd_valid <= 1'b0;
            end
        end

        if (rd_en) begin
            rd_data <= mem[rd_ptr[$clog2(DEPTH)-1:0]];
        end
    end

endmodule

// ==== hdl/udp_pkg.sv ====
// shared constants for the UDP checksum core
// input and output header structs, payload beat struct
// checksum FSM state encoding

package udp_pkg;

    // UDP header length in bytes, also the start value of the length counter
    localparam logic [15:0] UDP_HDR_LEN = 16'd8;

    // IPv4 header without options
    localparam logic [15:0] IP_HDR_LEN = 16'd20;

    // protocol number as it appears in the pseudo header
    localparam logic [7:0] UDP_PROTO = 8'h11;

    // payload buffer in bytes
    localparam int PAYLOAD_FIFO_DEPTH = 256;

    // finished headers waiting for the consumer
    localparam int HEADER_FIFO_DEPTH = 8;

    // header as presented by the sender, 96 bits
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
    } udp_in_hdr_t;

    // header with length and checksum filled in, 128 bits
    typedef struct packed {
        logic [31:0] ip_source_ip;
        logic [31:0] ip_dest_ip;
        logic [15:0] udp_source_port;
        logic [15:0] udp_dest_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } udp_out_hdr_t;

    // one payload byte
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } udp_beat_t;

    // checksum FSM
    // three header states add the pseudo header and UDP header words
    typedef enum logic [2:0] {
        idle        = 3'd0,
        sum_hdr_1   = 3'd1,
        sum_hdr_2   = 3'd2,
        sum_hdr_3   = 3'd3,
        sum_payload = 3'd4,
        finish      = 3'd5
    } csum_state_t;

endpackage
